/* Makefile */
# Verilator build and run of the ALU functional unit testbench

VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list the targets"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Test failed: no pass message"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
+incdir+verilog
+incdir+verif
verilog/alu_pkg.sv
verilog/alu_adder_cmp.sv
verilog/alu_shifter.sv
verilog/polar_simd.sv
verilog/alu_result_mux.sv
verilog/alu_fu_ctrl.sv
verilog/alu_top.sv
verif/alu_tb.sv

/* verif/alu_tb_vectors.svh */
// ALU testbench vectors
// Directed stimulus with expected results, and the xorshift generator

`ifndef ALU_TB_VECTORS_SVH
`define ALU_TB_VECTORS_SVH

localparam int NUM_VECTORS = 35;

// One directed vector; hold is the number of extra cycles req_i stays high
typedef struct packed {
    alu_pkg::alu_op_e       op;
    logic [`ALU_XLEN-1:0]   a;
    logic [`ALU_XLEN-1:0]   b;
    logic [`ALU_XLEN-1:0]   result;
    logic                   taken;
    logic [3:0]             hold;
} vector_t;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{alu_pkg::ADD,  64'h5, 64'h3, 64'h8, 1'b1, 4'd0},
    '{alu_pkg::ADD,  64'hffffffffffffffff, 64'h1, 64'h0, 1'b1, 4'd0},
    '{alu_pkg::SUB,  64'h5, 64'h7, 64'hfffffffffffffffe, 1'b1, 4'd3},
    '{alu_pkg::ADDW, 64'h7fffffff, 64'h1, 64'hffffffff80000000, 1'b1, 4'd0},
    '{alu_pkg::SUBW, 64'h1234567800000001, 64'h2, 64'hffffffffffffffff, 1'b1, 4'd0},
    '{alu_pkg::ANDL, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00,
      64'hf000f000f000f000, 1'b1, 4'd0},
    '{alu_pkg::ORL,  64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00,
      64'hfff0fff0fff0fff0, 1'b1, 4'd0},
    '{alu_pkg::XORL, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00,
      64'h0ff00ff00ff00ff0, 1'b1, 4'd0},
    // Top bit set: negative when signed, huge when unsigned
    '{alu_pkg::SLTS, 64'h8000000000000000, 64'h1, 64'h1, 1'b1, 4'd0},
    '{alu_pkg::SLTU, 64'h8000000000000000, 64'h1, 64'h0, 1'b1, 4'd2},
    '{alu_pkg::EQ,   64'h1234, 64'h1234, 64'h0, 1'b1, 4'd0},
    '{alu_pkg::EQ,   64'h1234, 64'h1235, 64'h0, 1'b0, 4'd0},
    '{alu_pkg::NE,   64'h1, 64'h2, 64'h0, 1'b1, 4'd0},
    '{alu_pkg::NE,   64'h2, 64'h2, 64'h0, 1'b0, 4'd2},
    '{alu_pkg::LTS,  64'hffffffffffffffff, 64'h0, 64'h0, 1'b1, 4'd0},
    '{alu_pkg::LTU,  64'hffffffffffffffff, 64'h0, 64'h0, 1'b0, 4'd0},
    '{alu_pkg::GES,  64'hffffffffffffffff, 64'h0, 64'h0, 1'b0, 4'd0},
    '{alu_pkg::GEU,  64'hffffffffffffffff, 64'h0, 64'h0, 1'b1, 4'd4},
    '{alu_pkg::SLL,  64'h8000000000000001, 64'h0, 64'h8000000000000001, 1'b1, 4'd0},
    '{alu_pkg::SLL,  64'h8000000000000001, 64'h1, 64'h2, 1'b1, 4'd0},
    '{alu_pkg::SLL,  64'h1, 64'd63, 64'h8000000000000000, 1'b1, 4'd0},
    '{alu_pkg::SRL,  64'h8000000000000000, 64'h0, 64'h8000000000000000, 1'b1, 4'd0},
    '{alu_pkg::SRL,  64'h8000000000000000, 64'h1, 64'h4000000000000000, 1'b1, 4'd0},
    '{alu_pkg::SRL,  64'h8000000000000000, 64'd63, 64'h1, 1'b1, 4'd0},
    '{alu_pkg::SRA,  64'h8000000000000000, 64'h0, 64'h8000000000000000, 1'b1, 4'd0},
    '{alu_pkg::SRA,  64'h8000000000000000, 64'h1, 64'hc000000000000000, 1'b1, 4'd0},
    '{alu_pkg::SRA,  64'h8000000000000000, 64'd63, 64'hffffffffffffffff, 1'b1, 4'd1},
    '{alu_pkg::SLLW, 64'h1, 64'd31, 64'hffffffff80000000, 1'b1, 4'd0},
    '{alu_pkg::SRLW, 64'hffffffff80000000, 64'd31, 64'h1, 1'b1, 4'd0},
    '{alu_pkg::SRAW, 64'h80000000, 64'd31, 64'hffffffffffffffff, 1'b1, 4'd0},
    '{alu_pkg::LDN_MIN, 64'h05fb807f000110f0, 64'h03057f80ff02f010,
      64'h03fb8080ff01f0f0, 1'b1, 4'd0},
    // Lanes above 63 clamp, negative lanes keep their low byte
    '{alu_pkg::LDN_ADDSAT, 64'h407f20f08001c000, 64'h407f1ff08002203f,
      64'h3f3f3fe00003e03f, 1'b1, 4'd2},
    '{alu_pkg::LDN_SUBSAT, 64'h7f40008010c03f01, 64'h80c0017f2040ff01,
      64'h3f3fff01f0803f00, 1'b1, 4'd0},
    '{alu_pkg::LDN_HMIN, 64'h8040ff209035a0c0, 64'hffffffffffffff10, 64'h10, 1'b1, 4'd0},
    '{alu_pkg::LDN_HMIN, 64'h8040ff209035a0c0, 64'hf0, 64'h20, 1'b1, 4'd3}
};

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`endif

/* verif/alu_tb.sv */
// ALU functional unit testbench
// Drives the four-phase handshake with directed and random vectors,
// checks latency, results and the hold behavior while req stays high

`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_tb;

    localparam int          CLK_PERIOD        = 10;
    localparam int          RESET_CYCLES      = 2;
    localparam int          NUM_RANDOM        = 12;
    localparam int          CYCLES_PER_VECTOR = 20;
    localparam logic [31:0] RNG_SEED          = 32'h30b2_d260;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 req_i;
    alu_pkg::alu_req_t    req_data_i;
    logic                 ack_o;
    alu_pkg::alu_resp_t   resp_o;

    `include "alu_tb_vectors.svh"

    alu_top dut_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .ack_o      (ack_o),
        .resp_o     (resp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Budget covers every vector plus reset
    initial begin
        #(CLK_PERIOD * (CYCLES_PER_VECTOR * (NUM_VECTORS + NUM_RANDOM) + RESET_CYCLES));
        $display("Handshake timed out: ack_o did not respond in time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // --------------------------------------------------
    // One full four-phase transaction
    // --------------------------------------------------
    task automatic run_vector(input alu_pkg::alu_req_t req, input alu_pkg::alu_resp_t expected,
                              input int hold);
        int edges;
        check_value("ack_o", 64'(ack_o), 64'd0);
        @(posedge clk_i);
        req_i      <= 1'b1;
        req_data_i <= req;
        edges = 0;
        do begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
        end while (!ack_o);
        check_value("ack_o latency", 64'(edges), 64'd2);
        check_value("resp_o.result", resp_o.result, expected.result);
        check_value("resp_o.branch_taken", 64'(resp_o.branch_taken),
                    64'(expected.branch_taken));
        // Back-pressure: ack and result must hold
        repeat (hold) begin
            @(negedge clk_i);
            check_value("ack_o", 64'(ack_o), 64'd1);
            check_value("resp_o.result", resp_o.result, expected.result);
            check_value("resp_o.branch_taken", 64'(resp_o.branch_taken),
                        64'(expected.branch_taken));
        end
        @(posedge clk_i);
        req_i <= 1'b0;
        // The drive edge still samples req_i high
        @(negedge clk_i);
        check_value("ack_o", 64'(ack_o), 64'd1);
        edges = 0;
        do begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
        end while (ack_o);
        check_value("ack_o release", 64'(edges), 64'd1);
    endtask

    initial begin
        alu_pkg::alu_req_t    req;
        alu_pkg::alu_resp_t   expected;
        logic [31:0]          rng;
        rst_n_i    = 1'b0;
        req_i      = 1'b0;
        req_data_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("ack_o", 64'(ack_o), 64'd0);
        check_value("resp_o.result", resp_o.result, 64'd0);
        check_value("resp_o.branch_taken", 64'(resp_o.branch_taken), 64'd0);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            req.op                = VECTORS[i].op;
            req.operand_a         = VECTORS[i].a;
            req.operand_b         = VECTORS[i].b;
            expected.result       = VECTORS[i].result;
            expected.branch_taken = VECTORS[i].taken;
            run_vector(req, expected, int'(VECTORS[i].hold));
        end

        // Random operands for ADD, XOR and SLL
        rng = RNG_SEED;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng = xorshift32(rng);
            req.operand_a[63:32] = rng;
            rng = xorshift32(rng);
            req.operand_a[31:0] = rng;
            rng = xorshift32(rng);
            req.operand_b[63:32] = rng;
            rng = xorshift32(rng);
            req.operand_b[31:0] = rng;
            case (i % 3)
                0: begin
                    req.op          = alu_pkg::ADD;
                    expected.result = req.operand_a + req.operand_b;
                end
                1: begin
                    req.op          = alu_pkg::XORL;
                    expected.result = req.operand_a ^ req.operand_b;
                end
                default: begin
                    req.op          = alu_pkg::SLL;
                    expected.result = req.operand_a << req.operand_b[5:0];
                end
            endcase
            expected.branch_taken = 1'b1;
            run_vector(req, expected, i % 2);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/alu_adder_cmp.sv */
// ALU adder and comparator
// Add/subtract with a carry-in bit, zero flag, signed or unsigned
// less-than, and branch condition resolution

`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_adder_cmp (
    input  alu_pkg::alu_req_t       op_i,
    output logic [`ALU_XLEN-1:0]    adder_result_o,
    output logic                    less_o,
    output logic                    branch_taken_o
);

    logic                 negate_b;
    logic                 signed_cmp;
    logic [`ALU_XLEN:0]   adder_in_a;
    logic [`ALU_XLEN:0]   adder_in_b;
    logic [`ALU_XLEN:0]   adder_sum;
    logic                 zero_flag;

    // Subtraction and equality tests need A - B
    always_comb begin
        case (op_i.op)
            alu_pkg::SUB, alu_pkg::SUBW,
            alu_pkg::EQ,  alu_pkg::NE:   negate_b = 1'b1;
            default:                     negate_b = 1'b0;
        endcase
    end

    // Extra low bit carries the +1 of the two's complement
    assign adder_in_a     = {op_i.operand_a, 1'b1};
    assign adder_in_b     = {op_i.operand_b, 1'b0} ^ {(`ALU_XLEN+1){negate_b}};
    assign adder_sum      = adder_in_a + adder_in_b;
    assign adder_result_o = adder_sum[`ALU_XLEN:1];
    assign zero_flag      = ~|adder_sum[`ALU_XLEN:1];

    // --------------------------------------------------
    // Comparison
    // --------------------------------------------------
    assign signed_cmp = (op_i.op == alu_pkg::SLTS) ||
                        (op_i.op == alu_pkg::LTS)  ||
                        (op_i.op == alu_pkg::GES);

    // One extra top bit turns the signed compare into an unsigned one
    assign less_o = $signed({signed_cmp & op_i.operand_a[`ALU_XLEN-1], op_i.operand_a}) <
                    $signed({signed_cmp & op_i.operand_b[`ALU_XLEN-1], op_i.operand_b});

    always_comb begin
        case (op_i.op)
            alu_pkg::EQ:                branch_taken_o = zero_flag;
            alu_pkg::NE:                branch_taken_o = ~zero_flag;
            alu_pkg::LTS, alu_pkg::LTU: branch_taken_o = less_o;
            alu_pkg::GES, alu_pkg::GEU: branch_taken_o = ~less_o;
            default:                    branch_taken_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu_config.svh */
// ALU configuration
// Datapath widths and the polar lane saturation limit

`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Full register width
`define ALU_XLEN    64
// Width of the W-suffixed operations
`define ALU_WORD_W  32

// Polar SIMD lane geometry
`define ALU_LANE_W  8
`define ALU_LANES   8

// Lane add/sub clamp only above this value
`define ALU_SAT_MAX 63

`endif

/* verilog/alu_fu_ctrl.sv */
// ALU functional unit controller
// Four-phase req/ack FSM with registered operands and result;
// request to ack takes two clock edges

`timescale 1ns/1ps
`default_nettype none

module alu_fu_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  alu_pkg::alu_req_t    req_data_i,
    input  alu_pkg::alu_resp_t   resp_d_i,
    output alu_pkg::alu_req_t    op_o,
    output logic                 ack_o,
    output alu_pkg::alu_resp_t   resp_o
);

    alu_pkg::fu_state_e   state_q;
    alu_pkg::fu_state_e   state_d;
    alu_pkg::alu_req_t    op_q;
    alu_pkg::alu_resp_t   resp_q;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            alu_pkg::FU_IDLE: begin
                if (req_i) begin
                    state_d = alu_pkg::FU_EXEC;
                end
            end
            alu_pkg::FU_EXEC: begin
                state_d = alu_pkg::FU_DONE;
            end
            alu_pkg::FU_DONE: begin
                // Hold the result until the requester lets go
                if (!req_i) begin
                    state_d = alu_pkg::FU_IDLE;
                end
            end
            default: begin
                state_d = alu_pkg::FU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= alu_pkg::FU_IDLE;
            op_q    <= '0;
            resp_q  <= '0;
        end else begin
            state_q <= state_d;
            // Capture operands on request
            if (state_q == alu_pkg::FU_IDLE && req_i) begin
                op_q <= req_data_i;
            end
            // Datapath has settled during EXEC
            if (state_q == alu_pkg::FU_EXEC) begin
                resp_q <= resp_d_i;
            end
        end
    end

    assign op_o   = op_q;
    assign resp_o = resp_q;
    assign ack_o  = (state_q == alu_pkg::FU_DONE);

endmodule

`default_nettype wire

/* verilog/alu_pkg.sv */
// ALU package
// Operation and controller state encodings, request and response structs

`default_nettype none

`include "alu_config.svh"

package alu_pkg;

    // Operations handled by the unit
    typedef enum logic [4:0] {
        ADD, SUB, ADDW, SUBW,
        ANDL, ORL, XORL,
        SLTS, SLTU,
        EQ, NE, LTS, LTU, GES, GEU,
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        LDN_MIN, LDN_ADDSAT, LDN_SUBSAT, LDN_HMIN
    } alu_op_e;

    // Handshake controller states
    typedef enum logic [1:0] {
        FU_IDLE,
        FU_EXEC,
        FU_DONE
    } fu_state_e;

    typedef struct packed {
        alu_op_e               op;
        logic [`ALU_XLEN-1:0]  operand_a;
        logic [`ALU_XLEN-1:0]  operand_b;
    } alu_req_t;

    typedef struct packed {
        logic [`ALU_XLEN-1:0]  result;
        logic                  branch_taken;
    } alu_resp_t;

endpackage

`default_nettype wire

/* verilog/alu_result_mux.sv */
// ALU result multiplexer
// Bitwise logic operations and the final per-operation result select

`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_result_mux (
    input  alu_pkg::alu_req_t        op_i,
    input  logic [`ALU_XLEN-1:0]     adder_result_i,
    input  logic                     less_i,
    input  logic                     branch_taken_i,
    input  logic [`ALU_XLEN-1:0]     shift_result_i,
    input  logic [`ALU_WORD_W-1:0]   shift_result_w_i,
    input  logic [`ALU_XLEN-1:0]     polar_result_i,
    output alu_pkg::alu_resp_t       resp_o
);

    logic [`ALU_XLEN-1:0] and_result;
    logic [`ALU_XLEN-1:0] or_result;
    logic [`ALU_XLEN-1:0] xor_result;

    assign and_result = op_i.operand_a & op_i.operand_b;
    assign or_result  = op_i.operand_a | op_i.operand_b;
    assign xor_result = op_i.operand_a ^ op_i.operand_b;

    assign resp_o.branch_taken = branch_taken_i;

    always_comb begin
        case (op_i.op)
            alu_pkg::ADD, alu_pkg::SUB: resp_o.result = adder_result_i;
            // Word results are sign extended from bit 31
            alu_pkg::ADDW, alu_pkg::SUBW:
                resp_o.result = {{(`ALU_XLEN-`ALU_WORD_W){adder_result_i[`ALU_WORD_W-1]}},
                                 adder_result_i[`ALU_WORD_W-1:0]};
            alu_pkg::ANDL: resp_o.result = and_result;
            alu_pkg::ORL:  resp_o.result = or_result;
            alu_pkg::XORL: resp_o.result = xor_result;
            alu_pkg::SLTS, alu_pkg::SLTU:
                resp_o.result = {{(`ALU_XLEN-1){1'b0}}, less_i};
            alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA: resp_o.result = shift_result_i;
            alu_pkg::SLLW, alu_pkg::SRLW, alu_pkg::SRAW:
                resp_o.result = {{(`ALU_XLEN-`ALU_WORD_W){shift_result_w_i[`ALU_WORD_W-1]}},
                                 shift_result_w_i};
            alu_pkg::LDN_MIN, alu_pkg::LDN_ADDSAT,
            alu_pkg::LDN_SUBSAT, alu_pkg::LDN_HMIN: resp_o.result = polar_result_i;
            // Branches only report the taken flag
            default: resp_o.result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu_shifter.sv */
// ALU shifter
// One arithmetic/logical right shifter per width; left shifts reverse
// the operand before and after the right shift

`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_shifter (
    input  alu_pkg::alu_req_t        op_i,
    output logic [`ALU_XLEN-1:0]     shift_result_o,
    output logic [`ALU_WORD_W-1:0]   shift_result_w_o
);

    localparam int SHAMT_W   = $clog2(`ALU_XLEN);
    localparam int SHAMT_W_W = $clog2(`ALU_WORD_W);

    logic                     shift_left;
    logic                     shift_arith;
    logic [`ALU_XLEN-1:0]     op_a_rev;
    logic [`ALU_WORD_W-1:0]   op_a_rev_w;
    logic [`ALU_XLEN-1:0]     shift_in;
    logic [`ALU_WORD_W-1:0]   shift_in_w;
    logic [`ALU_XLEN:0]       right_result;
    logic [`ALU_WORD_W:0]     right_result_w;
    logic [`ALU_XLEN-1:0]     left_result;
    logic [`ALU_WORD_W-1:0]   left_result_w;

    assign shift_left  = (op_i.op == alu_pkg::SLL) || (op_i.op == alu_pkg::SLLW);
    assign shift_arith = (op_i.op == alu_pkg::SRA) || (op_i.op == alu_pkg::SRAW);

    // Bit reversal of operand A and of the right shift result
    for (genvar i = 0; i < `ALU_XLEN; i++) begin : g_rev
        assign op_a_rev[i]    = op_i.operand_a[`ALU_XLEN-1-i];
        assign left_result[i] = right_result[`ALU_XLEN-1-i];
    end

    for (genvar i = 0; i < `ALU_WORD_W; i++) begin : g_rev_w
        assign op_a_rev_w[i]    = op_i.operand_a[`ALU_WORD_W-1-i];
        assign left_result_w[i] = right_result_w[`ALU_WORD_W-1-i];
    end

    assign shift_in   = shift_left ? op_a_rev   : op_i.operand_a;
    assign shift_in_w = shift_left ? op_a_rev_w : op_i.operand_a[`ALU_WORD_W-1:0];

    // Top bit is the fill value: sign for SRA/SRAW, zero otherwise
    assign right_result   = $signed({shift_arith & shift_in[`ALU_XLEN-1], shift_in})
                            >>> op_i.operand_b[SHAMT_W-1:0];
    assign right_result_w = $signed({shift_arith & shift_in_w[`ALU_WORD_W-1], shift_in_w})
                            >>> op_i.operand_b[SHAMT_W_W-1:0];

    assign shift_result_o   = shift_left ? left_result : right_result[`ALU_XLEN-1:0];
    assign shift_result_w_o = shift_left ? left_result_w : right_result_w[`ALU_WORD_W-1:0];

endmodule

`default_nettype wire

/* verilog/alu_top.sv */
// ALU functional unit top level
// Handshake controller feeding the adder, shifter, polar SIMD unit
// and the result multiplexer

`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  alu_pkg::alu_req_t    req_data_i,
    output logic                 ack_o,
    output alu_pkg::alu_resp_t   resp_o
);

    alu_pkg::alu_req_t        op_q;
    alu_pkg::alu_resp_t       resp_d;
    logic [`ALU_XLEN-1:0]     adder_result;
    logic                     less;
    logic                     branch_taken;
    logic [`ALU_XLEN-1:0]     shift_result;
    logic [`ALU_WORD_W-1:0]   shift_result_w;
    logic [`ALU_XLEN-1:0]     polar_result;

    alu_fu_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .resp_d_i   (resp_d),
        .op_o       (op_q),
        .ack_o      (ack_o),
        .resp_o     (resp_o)
    );

    alu_adder_cmp u_adder_cmp (
        .op_i           (op_q),
        .adder_result_o (adder_result),
        .less_o         (less),
        .branch_taken_o (branch_taken)
    );

    alu_shifter u_shifter (
        .op_i             (op_q),
        .shift_result_o   (shift_result),
        .shift_result_w_o (shift_result_w)
    );

    polar_simd u_polar (
        .op_i           (op_q),
        .polar_result_o (polar_result)
    );

    alu_result_mux u_result_mux (
        .op_i             (op_q),
        .adder_result_i   (adder_result),
        .less_i           (less),
        .branch_taken_i   (branch_taken),
        .shift_result_i   (shift_result),
        .shift_result_w_i (shift_result_w),
        .polar_result_i   (polar_result),
        .resp_o           (resp_d)
    );

endmodule

`default_nettype wire

/* verilog/polar_simd.sv */
// Polar decoding SIMD unit
// Byte-lane signed min, saturating add and subtract, and a horizontal
// unsigned minimum of operand A against the low byte of B

`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module polar_simd (
    input  alu_pkg::alu_req_t      op_i,
    output logic [`ALU_XLEN-1:0]   polar_result_o
);

    localparam logic signed [`ALU_LANE_W:0] SAT_MAX = `ALU_SAT_MAX;

    logic [`ALU_XLEN-1:0]     lane_min;
    logic [`ALU_XLEN-1:0]     lane_addsat;
    logic [`ALU_XLEN-1:0]     lane_subsat;
    logic [`ALU_LANE_W-1:0]   lvl1 [`ALU_LANES/2];
    logic [`ALU_LANE_W-1:0]   lvl2 [`ALU_LANES/4];
    logic [`ALU_LANE_W-1:0]   lvl3;
    logic [`ALU_LANE_W-1:0]   hmin_byte;

    function automatic logic [`ALU_LANE_W-1:0] umin(input logic [`ALU_LANE_W-1:0] x,
                                                    input logic [`ALU_LANE_W-1:0] y);
        return (x > y) ? y : x;
    endfunction

    // --------------------------------------------------
    // Per-lane operations
    // --------------------------------------------------
    for (genvar l = 0; l < `ALU_LANES; l++) begin : g_lane
        logic signed [`ALU_LANE_W-1:0] a_s;
        logic signed [`ALU_LANE_W-1:0] b_s;
        logic signed [`ALU_LANE_W:0]   sum;
        logic signed [`ALU_LANE_W:0]   diff;

        assign a_s  = op_i.operand_a[l*`ALU_LANE_W +: `ALU_LANE_W];
        assign b_s  = op_i.operand_b[l*`ALU_LANE_W +: `ALU_LANE_W];
        assign sum  = a_s + b_s;
        assign diff = a_s - b_s;

        assign lane_min[l*`ALU_LANE_W +: `ALU_LANE_W] = (a_s >= b_s) ? b_s : a_s;

        // Clamp on the high side only; negative results keep their low byte
        assign lane_addsat[l*`ALU_LANE_W +: `ALU_LANE_W] =
            (sum > SAT_MAX) ? SAT_MAX[`ALU_LANE_W-1:0] : sum[`ALU_LANE_W-1:0];
        assign lane_subsat[l*`ALU_LANE_W +: `ALU_LANE_W] =
            (diff > SAT_MAX) ? SAT_MAX[`ALU_LANE_W-1:0] : diff[`ALU_LANE_W-1:0];
    end

    // Horizontal min tree, three levels
    for (genvar n = 0; n < `ALU_LANES/2; n++) begin : g_lvl1
        assign lvl1[n] = umin(op_i.operand_a[(2*n)*`ALU_LANE_W +: `ALU_LANE_W],
                              op_i.operand_a[(2*n+1)*`ALU_LANE_W +: `ALU_LANE_W]);
    end

    for (genvar n = 0; n < `ALU_LANES/4; n++) begin : g_lvl2
        assign lvl2[n] = umin(lvl1[2*n], lvl1[2*n+1]);
    end

    assign lvl3      = umin(lvl2[0], lvl2[1]);
    assign hmin_byte = umin(lvl3, op_i.operand_b[`ALU_LANE_W-1:0]);

    always_comb begin
        case (op_i.op)
            alu_pkg::LDN_MIN:    polar_result_o = lane_min;
            alu_pkg::LDN_ADDSAT: polar_result_o = lane_addsat;
            alu_pkg::LDN_SUBSAT: polar_result_o = lane_subsat;
            alu_pkg::LDN_HMIN:   polar_result_o = {{(`ALU_XLEN-`ALU_LANE_W){1'b0}}, hmin_byte};
            default:             polar_result_o = '0;
        endcase
    end

endmodule

`default_nettype wire
